// ==== hw/controlPkg.sv ====
package controlPkg;

	localparam int opCodeWidth = 6;
	localparam int functWidth = 6;
	localparam int aluSrcAWidth = 2;
	localparam int aluSrcBWidth = 3;
	localparam int pcSourceWidth = 3;
	localparam int aluOpWidth = 3;
	localparam int iOrDWidth = 2;
	localparam int memToRegWidth = 4;
	localparam int regDstWidth = 2;
	localparam int shiftControlWidth = 3;
	localparam int stepWidth = 2;

	localparam logic [stepWidth-1:0] fetchSteps = 2'd3;  // Address, memory wait, IR load
	localparam logic [stepWidth-1:0] shiftExecuteSteps = 2'd2;

	localparam logic [aluOpWidth-1:0] aluAdd = 3'd1;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
	localparam logic [aluOpWidth-1:0] aluCompare = 3'd7;

	localparam logic [shiftControlWidth-1:0] shiftLoad = 3'd1;
	localparam logic [shiftControlWidth-1:0] shiftLeft = 3'd2;
	localparam logic [shiftControlWidth-1:0] shiftRightLogical = 3'd3;
	localparam logic [shiftControlWidth-1:0] shiftRightArith = 3'd4;

	localparam logic [memToRegWidth-1:0] memToRegShift = 4'd4;
	localparam logic [memToRegWidth-1:0] memToRegSlt = 4'd8;
	localparam logic [regDstWidth-1:0] regDstRd = 2'd3;
	localparam logic [iOrDWidth-1:0] exceptionAddress = 2'd3;

	typedef enum logic [2:0] {
		phaseReset,
		phaseFetch,
		phaseDecode,
		phaseExecute,
		phaseFinish,
		phaseException,
		phaseWait
	} phaseT;

	typedef enum logic [4:0] {
		instrAdd,
		instrAnd,
		instrSub,
		instrSlt,
		instrSll,
		instrSrl,
		instrSra,
		instrSllv,
		instrSrav,
		instrJr,
		instrRte,
		instrBreak,
		instrAddi,
		instrAddiu,
		instrLui,
		instrBeq,
		instrBne,
		instrBgt,
		instrBle,
		instrIllegal
	} instrT;

endpackage

// ==== hw/sequenceIf.sv ====
`timescale 1ns/1ps

interface sequenceIf import controlPkg::*; (
	input logic clock
);

	phaseT phase;
	instrT instr;
	logic load;
	logic [stepWidth-1:0] stepCount;  // Phase length, valid with load
	logic [stepWidth-1:0] step;
	logic lastStep;

	modport sequencer (
		output phase, instr, load, stepCount,
		input step, lastStep
	);

	modport counter (
		input load, stepCount,
		output step, lastStep
	);

	modport controlTable (
		input clock, phase, instr, step
	);

endinterface

// ==== hw/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder import controlPkg::*; (
	input logic [opCodeWidth-1:0] opCode,
	input logic [functWidth-1:0] funct,
	output instrT instr
);

	instrT rTypeInstr;

	always_comb begin
		case (funct)
			6'h20: rTypeInstr = instrAdd;
			6'h24: rTypeInstr = instrAnd;
			6'h22: rTypeInstr = instrSub;
			6'h2a: rTypeInstr = instrSlt;
			6'h00: rTypeInstr = instrSll;
			6'h02: rTypeInstr = instrSrl;
			6'h03: rTypeInstr = instrSra;
			6'h04: rTypeInstr = instrSllv;
			6'h07: rTypeInstr = instrSrav;
			6'h08: rTypeInstr = instrJr;
			6'h13: rTypeInstr = instrRte;
			6'h0d: rTypeInstr = instrBreak;
			default: rTypeInstr = instrIllegal;
		endcase
	end

	always_comb begin
		case (opCode)
			6'h00: instr = rTypeInstr;  // Funct only matters for R-type
			6'h04: instr = instrBeq;
			6'h05: instr = instrBne;
			6'h06: instr = instrBle;
			6'h07: instr = instrBgt;
			6'h08: instr = instrAddi;
			6'h09: instr = instrAddiu;
			6'h0f: instr = instrLui;
			default: instr = instrIllegal;  // Loads land here too
		endcase
	end

endmodule

// ==== hw/stepCounter.sv ====
`timescale 1ns/1ps

module stepCounter import controlPkg::*; (
	input logic clock,
	input logic reset,
	sequenceIf.counter seq
);

	logic [stepWidth-1:0] stepLength;

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			seq.step <= '0;
			stepLength <= stepWidth'(1);
		end else if (seq.load) begin
			seq.step <= '0;
			stepLength <= seq.stepCount;
		end else if (!seq.lastStep) begin
			seq.step <= seq.step + 1'b1;  // Holds on the last step until the next load
		end
	end

	assign seq.lastStep = (seq.step == stepLength - 1'b1);

	stepInRange: assert property (@(posedge clock) disable iff (reset)
		seq.step < stepLength);

endmodule

// ==== hw/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer import controlPkg::*; (
	input logic clock,
	input logic reset,
	input instrT decoded,
	input logic overflow,
	sequenceIf.sequencer seq
);

	phaseT nextPhase;
	logic [stepWidth-1:0] executeSteps;
	logic enterFetch;
	logic enterExecute;

	// Decoded is still valid in Decode, so Execute length comes from it directly
	always_comb begin
		case (decoded)
			instrSll, instrSrl, instrSra, instrSllv, instrSrav: begin
				executeSteps = shiftExecuteSteps;
			end
			default: begin
				executeSteps = stepWidth'(1);
			end
		endcase
	end

	always_comb begin
		nextPhase = seq.phase;
		case (seq.phase)
			phaseReset: begin
				nextPhase = phaseFetch;
			end
			phaseFetch: begin
				if (seq.lastStep) begin
					nextPhase = phaseDecode;
				end
			end
			phaseDecode: begin
				if (decoded == instrIllegal) begin
					nextPhase = phaseWait;  // Nothing is written for an unknown code
				end else begin
					nextPhase = phaseExecute;
				end
			end
			phaseExecute: begin
				if (seq.lastStep) begin
					case (seq.instr)
						instrSlt, instrJr, instrRte: nextPhase = phaseWait;
						instrAddi: nextPhase = overflow ? phaseException : phaseFinish;
						default: nextPhase = phaseFinish;
					endcase
				end
			end
			phaseFinish, phaseException: begin
				nextPhase = phaseWait;
			end
			default: begin
				nextPhase = phaseFetch;
			end
		endcase
	end

	assign enterFetch = (nextPhase == phaseFetch) && (seq.phase != phaseFetch);
	assign enterExecute = (nextPhase == phaseExecute) && (seq.phase != phaseExecute);

	assign seq.load = enterFetch || enterExecute;  // Counter shows step 0 in the new phase
	assign seq.stepCount = enterFetch ? fetchSteps : executeSteps;

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			seq.phase <= phaseReset;
			seq.instr <= instrIllegal;
		end else begin
			seq.phase <= nextPhase;
			if (seq.phase == phaseDecode) begin
				seq.instr <= decoded;
			end
		end
	end

	waitThenFetch: assert property (@(posedge clock) disable iff (reset)
		seq.phase == phaseWait |=> seq.phase == phaseFetch && seq.step == '0);

endmodule

// ==== hw/controlSignalTable.sv ====
`timescale 1ns/1ps

module controlSignalTable import controlPkg::*; (
	sequenceIf.controlTable seq,
	input logic equal,
	input logic greaterThan,
	output logic [aluSrcAWidth-1:0] aluSrcA,
	output logic [aluSrcBWidth-1:0] aluSrcB,
	output logic [pcSourceWidth-1:0] pcSource,
	output logic [aluOpWidth-1:0] aluOp,
	output logic pcWrite,
	output logic irWrite,
	output logic [iOrDWidth-1:0] iOrD,
	output logic [memToRegWidth-1:0] memToReg,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutWrite,
	output logic [regDstWidth-1:0] regDst,
	output logic regWrite,
	output logic epcWrite,
	output logic [shiftControlWidth-1:0] shiftControl,
	output logic shiftSrc,
	output logic shiftAmt
);

	logic immediateShift;
	logic variableShift;
	logic branchTaken;
	logic [shiftControlWidth-1:0] shiftKind;
	logic [aluOpWidth-1:0] rTypeOp;

	assign immediateShift = seq.instr inside {instrSll, instrSrl, instrSra};
	assign variableShift = seq.instr inside {instrSllv, instrSrav};

	always_comb begin
		shiftKind = shiftLeft;
		rTypeOp = aluAnd;
		branchTaken = 1'b0;
		case (seq.instr)
			instrSrl: shiftKind = shiftRightLogical;
			instrSra, instrSrav: shiftKind = shiftRightArith;
			instrAdd: rTypeOp = aluAdd;
			instrSub: rTypeOp = aluSub;
			instrBeq: branchTaken = equal;
			instrBne: branchTaken = !equal;
			instrBgt: branchTaken = greaterThan;
			instrBle: branchTaken = !greaterThan;
			default: ;
		endcase
	end

	always_comb begin
		aluSrcA = '0;
		aluSrcB = '0;
		pcSource = '0;
		aluOp = '0;
		pcWrite = 1'b0;
		irWrite = 1'b0;
		iOrD = '0;
		memToReg = '0;
		writeRegA = 1'b0;
		writeRegB = 1'b0;
		aluOutWrite = 1'b0;
		regDst = '0;
		regWrite = 1'b0;
		epcWrite = 1'b0;
		shiftControl = '0;
		shiftSrc = 1'b0;
		shiftAmt = 1'b0;
		case (seq.phase)
			phaseReset: begin
				regDst = 2'd1;
				regWrite = 1'b1;
				epcWrite = 1'b1;
			end
			phaseFetch: begin
				if (seq.step == 2'd0) begin
					aluSrcB = 3'd1;  // PC + 4
					aluOp = aluAdd;
					pcWrite = 1'b1;
				end
				irWrite = (seq.step == fetchSteps - 1'b1);
			end
			phaseDecode: begin
				writeRegA = 1'b1;
				writeRegB = 1'b1;
			end
			phaseExecute: begin
				case (seq.instr)
					instrAdd, instrAnd, instrSub: begin
						aluSrcA = 2'd2;
						aluOp = rTypeOp;
						aluOutWrite = 1'b1;
					end
					instrSlt: begin
						aluSrcA = 2'd2;
						aluOp = aluCompare;
						memToReg = memToRegSlt;
						writeRegA = 1'b1;
						writeRegB = 1'b1;
						regDst = regDstRd;
						regWrite = 1'b1;
					end
					instrJr: begin
						pcSource = 3'd4;
						pcWrite = 1'b1;
						writeRegA = 1'b1;
					end
					instrRte: begin
						pcSource = 3'd3;  // Back to EPC
						pcWrite = 1'b1;
					end
					instrBreak: begin
						aluSrcB = 3'd1;
						aluOp = aluSub;
						aluOutWrite = 1'b1;
					end
					instrAddi, instrAddiu, instrLui: begin
						aluSrcA = (seq.instr == instrLui) ? 2'd1 : 2'd2;
						aluSrcB = 3'd2;
						aluOp = aluAdd;
						aluOutWrite = 1'b1;
					end
					instrBeq, instrBne, instrBgt, instrBle: begin
						aluSrcB = 3'd3;  // Branch target into ALUOut
						aluOp = aluAdd;
						aluOutWrite = 1'b1;
					end
					instrSll, instrSrl, instrSra, instrSllv, instrSrav: begin
						shiftControl = (seq.step == 2'd0) ? shiftLoad : shiftKind;
						shiftSrc = immediateShift;
						shiftAmt = immediateShift;
						writeRegA = variableShift;
						writeRegB = variableShift || (seq.step == 2'd0);
					end
					default: ;
				endcase
			end
			phaseFinish: begin
				case (seq.instr)
					instrAdd, instrAnd, instrSub: begin
						regDst = regDstRd;
						regWrite = 1'b1;
					end
					instrBreak: begin
						pcSource = 3'd1;
						pcWrite = 1'b1;
					end
					instrAddi, instrAddiu, instrLui: begin
						regWrite = 1'b1;
					end
					instrBeq, instrBne, instrBgt, instrBle: begin
						aluSrcA = 2'd2;
						aluOp = aluCompare;
						pcSource = 3'd1;
						writeRegA = 1'b1;
						writeRegB = 1'b1;
						pcWrite = branchTaken;
					end
					instrSll, instrSrl, instrSra, instrSllv, instrSrav: begin
						shiftControl = shiftKind;
						shiftSrc = immediateShift;
						shiftAmt = immediateShift;
						writeRegA = variableShift;
						writeRegB = variableShift;
						memToReg = memToRegShift;
						regDst = regDstRd;
						regWrite = 1'b1;
					end
					default: ;
				endcase
			end
			phaseException: begin
				iOrD = exceptionAddress;
				epcWrite = 1'b1;
			end
			default: ;
		endcase
	end

	noFetchClash: assert property (@(posedge seq.clock) !(pcWrite && irWrite));

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import controlPkg::*; (
	input logic clock,
	input logic reset,
	input logic [opCodeWidth-1:0] opCode,
	input logic [functWidth-1:0] funct,
	input logic overflow,
	input logic equal,
	input logic greaterThan,
	output logic [aluSrcAWidth-1:0] aluSrcA,
	output logic [aluSrcBWidth-1:0] aluSrcB,
	output logic [pcSourceWidth-1:0] pcSource,
	output logic [aluOpWidth-1:0] aluOp,
	output logic pcWrite,
	output logic irWrite,
	output logic [iOrDWidth-1:0] iOrD,
	output logic [memToRegWidth-1:0] memToReg,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutWrite,
	output logic [regDstWidth-1:0] regDst,
	output logic regWrite,
	output logic epcWrite,
	output logic [shiftControlWidth-1:0] shiftControl,
	output logic shiftSrc,
	output logic shiftAmt
);

	instrT decodedInstr;

	sequenceIf seq (
		.clock(clock)
	);

	instructionDecoder decoder (
		.opCode(opCode),
		.funct(funct),
		.instr(decodedInstr)
	);

	phaseSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.decoded(decodedInstr),
		.overflow(overflow),
		.seq(seq.sequencer)
	);

	stepCounter counter (
		.clock(clock),
		.reset(reset),
		.seq(seq.counter)
	);

	controlSignalTable signalTable (
		.seq(seq.controlTable),
		.equal(equal),
		.greaterThan(greaterThan),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.pcSource(pcSource),
		.aluOp(aluOp),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.iOrD(iOrD),
		.memToReg(memToReg),
		.writeRegA(writeRegA),
		.writeRegB(writeRegB),
		.aluOutWrite(aluOutWrite),
		.regDst(regDst),
		.regWrite(regWrite),
		.epcWrite(epcWrite),
		.shiftControl(shiftControl),
		.shiftSrc(shiftSrc),
		.shiftAmt(shiftAmt)
	);

endmodule

// ==== test/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb import controlPkg::*; ();

	localparam int fieldCount = 12;
	localparam int caseCount = 26;
	localparam int cycleLimit = 16;  // Longest instruction is 8 cycles

	logic clock;
	logic reset;
	logic [opCodeWidth-1:0] opCode;
	logic [functWidth-1:0] funct;
	logic overflow;
	logic equal;
	logic greaterThan;
	logic [aluSrcAWidth-1:0] aluSrcA;
	logic [aluSrcBWidth-1:0] aluSrcB;
	logic [pcSourceWidth-1:0] pcSource;
	logic [aluOpWidth-1:0] aluOp;
	logic pcWrite;
	logic irWrite;
	logic [iOrDWidth-1:0] iOrD;
	logic [memToRegWidth-1:0] memToReg;
	logic writeRegA;
	logic writeRegB;
	logic aluOutWrite;
	logic [regDstWidth-1:0] regDst;
	logic regWrite;
	logic epcWrite;
	logic [shiftControlWidth-1:0] shiftControl;
	logic shiftSrc;
	logic shiftAmt;

	logic [7:0] caseData [0:caseCount*fieldCount-1];
	int valueErrors;
	int otherErrors;
	bit timedOut;

	controlUnit dut (
		.clock(clock),
		.reset(reset),
		.opCode(opCode),
		.funct(funct),
		.overflow(overflow),
		.equal(equal),
		.greaterThan(greaterThan),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.pcSource(pcSource),
		.aluOp(aluOp),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.iOrD(iOrD),
		.memToReg(memToReg),
		.writeRegA(writeRegA),
		.writeRegB(writeRegB),
		.aluOutWrite(aluOutWrite),
		.regDst(regDst),
		.regWrite(regWrite),
		.epcWrite(epcWrite),
		.shiftControl(shiftControl),
		.shiftSrc(shiftSrc),
		.shiftAmt(shiftAmt)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	task automatic reportValue(input string name, input string what, input int expected,
		input int actual);
		valueErrors++;
		$display("[ERROR] %s: %s expected %0h actual %0h", name, what, expected, actual);
	endtask

	// Applies one case on the edge after irWrite and follows it to the next irWrite
	task automatic runCase(input int k);
		int base;
		int cycles;
		int regWrites;
		int epcWrites;
		int pcWrites;
		int pcWriteCycle [$];
		int pcWriteSource [$];
		logic [7:0] expCycles;
		logic [7:0] expAluOp;
		logic [7:0] expPcSource;
		logic [7:0] expShift;
		string name;
		base = k * fieldCount;
		name = $sformatf("case %0d (opCode %h funct %h)", k, caseData[base], caseData[base+1]);
		expCycles = caseData[base+5];
		expAluOp = caseData[base+9];
		expPcSource = caseData[base+10];
		expShift = caseData[base+11];
		@(posedge clock);
		opCode <= caseData[base][opCodeWidth-1:0];
		funct <= caseData[base+1][functWidth-1:0];
		overflow <= caseData[base+2][0];
		equal <= caseData[base+3][0];
		greaterThan <= caseData[base+4][0];
		cycles = 0;
		regWrites = 0;
		epcWrites = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles == 1 && {writeRegA, writeRegB} != 2'b11)  // Decode
				reportValue(name, "writeRegA and writeRegB", 3, {writeRegA, writeRegB});
			if (cycles == 2 && expAluOp != 8'hf && aluOp != expAluOp)  // First Execute cycle
				reportValue(name, "aluOp", expAluOp, aluOp);
			if (expShift != 0 && cycles == 2 && shiftControl != shiftLoad)
				reportValue(name, "shiftControl in first step", shiftLoad, shiftControl);
			if (expShift != 0 && cycles == 3 && shiftControl != expShift)
				reportValue(name, "shiftControl in second step", expShift, shiftControl);
			if (regWrite) begin
				regWrites++;
				if (expShift != 0 && memToReg != memToRegShift)
					reportValue(name, "memToReg", memToRegShift, memToReg);
				if (expShift != 0 && regDst != regDstRd)
					reportValue(name, "regDst", regDstRd, regDst);
			end
			if (epcWrite) begin
				epcWrites++;
				if (iOrD != exceptionAddress)
					reportValue(name, "iOrD", exceptionAddress, iOrD);
			end
			if (pcWrite) begin
				pcWriteCycle.push_back(cycles);
				pcWriteSource.push_back(pcSource);
			end
		end while (!irWrite && cycles < cycleLimit);
		if (!irWrite) begin
			otherErrors++;
			timedOut = 1'b1;
			$display("%s: irWrite never came back", name);
		end else begin
			if (cycles != expCycles)
				reportValue(name, "cycles between irWrite pulses", expCycles, cycles);
			if (regWrites != caseData[base+6])
				reportValue(name, "regWrite pulses", caseData[base+6], regWrites);
			if (epcWrites != caseData[base+8])
				reportValue(name, "epcWrite pulses", caseData[base+8], epcWrites);
			pcWrites = 0;
			foreach (pcWriteCycle[i]) begin
				if (pcWriteCycle[i] <= cycles - 3) begin  // Fetch fills the last three cycles
					pcWrites++;
					if (expPcSource != 8'hf && pcWriteSource[i] != expPcSource)
						reportValue(name, "pcSource", expPcSource, pcWriteSource[i]);
					if (expPcSource != 8'hf && pcWriteCycle[i] != cycles - 4)
						reportValue(name, "pcWrite cycle", cycles - 4, pcWriteCycle[i]);
				end
			end
			if (pcWrites != caseData[base+7])
				reportValue(name, "pcWrite pulses outside fetch", caseData[base+7], pcWrites);
		end
	endtask

	initial begin
		int i;
		int cycles;
		int quietOutputs;
		valueErrors = 0;
		otherErrors = 0;
		timedOut = 1'b0;
		reset = 1'b1;
		opCode = '0;
		funct = '0;
		overflow = 1'b0;
		equal = 1'b0;
		greaterThan = 1'b0;
		$readmemh("test/instructionCases.txt", caseData);

		for (i = 0; i < 4; i++) begin
			@(negedge clock);
			if (regWrite != 1'b1)
				reportValue("reset", "regWrite", 1, regWrite);
			if (epcWrite != 1'b1)
				reportValue("reset", "epcWrite", 1, epcWrite);
			if (regDst != 2'd1)
				reportValue("reset", "regDst", 1, regDst);
			if (pcWrite != 1'b0)
				reportValue("reset", "pcWrite", 0, pcWrite);
			if (irWrite != 1'b0)
				reportValue("reset", "irWrite", 0, irWrite);
			quietOutputs = {aluSrcA, aluSrcB, pcSource, aluOp, iOrD, memToReg, writeRegA,
				writeRegB, aluOutWrite, shiftControl, shiftSrc, shiftAmt};
			if (quietOutputs != 0)
				reportValue("reset", "remaining outputs", 0, quietOutputs);
		end
		@(posedge clock);
		reset <= 1'b0;

		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!pcWrite && cycles < cycleLimit);
		if (!pcWrite) begin
			otherErrors++;
			timedOut = 1'b1;
			$display("No pcWrite pulse after reset");
		end else begin
			if (aluOp != aluAdd)
				reportValue("first fetch", "aluOp", aluAdd, aluOp);
			if (aluSrcB != 3'd1)
				reportValue("first fetch", "aluSrcB", 1, aluSrcB);
			cycles = 0;
			do begin
				@(negedge clock);
				cycles++;
			end while (!irWrite && cycles < cycleLimit);
			if (!irWrite) begin
				otherErrors++;
				timedOut = 1'b1;
				$display("No irWrite pulse after the first fetch");
			end else if (cycles != 2) begin
				reportValue("first fetch", "cycles from pcWrite to irWrite", 2, cycles);
			end
		end

		for (i = 0; i < caseCount && !timedOut; i++) begin
			runCase(i);
		end

		$display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== test/instructionCases.txt ====
// opCode funct overflow equal greaterThan cycles regWrites pcWrites epcWrites
// then aluOp in the first Execute cycle, pcSource on pcWrite, shift kind (f is not checked)
00 20 0 0 0 07 1 0 0 1 f 0  // add
00 24 0 0 0 07 1 0 0 3 f 0  // and
00 22 0 0 0 07 1 0 0 2 f 0  // sub
00 2a 0 0 0 06 1 0 0 7 f 0  // slt
00 00 0 0 0 08 1 0 0 f f 2  // sll
00 02 0 0 0 08 1 0 0 f f 3  // srl
00 03 0 0 0 08 1 0 0 f f 4  // sra
00 04 0 0 0 08 1 0 0 f f 2  // sllv
00 07 0 0 0 08 1 0 0 f f 4  // srav
00 08 0 0 0 06 0 1 0 f f 0  // jr
00 13 0 0 0 06 0 1 0 f f 0  // rte
00 0d 0 0 0 07 0 1 0 f f 0  // break
08 00 1 0 0 07 0 0 1 f f 0  // addi with overflow
08 00 0 0 0 07 1 0 0 f f 0  // addi
09 00 1 0 0 07 1 0 0 f f 0  // addiu ignores overflow
0f 00 0 0 0 07 1 0 0 f f 0  // lui
04 00 0 1 0 07 0 1 0 f 1 0  // beq taken
04 00 0 0 1 07 0 0 0 f 1 0  // beq not taken
05 00 0 0 1 07 0 1 0 f 1 0  // bne taken
05 00 0 1 0 07 0 0 0 f 1 0  // bne not taken
07 00 0 0 1 07 0 1 0 f 1 0  // bgt taken
07 00 0 1 0 07 0 0 0 f 1 0  // bgt not taken
06 00 0 1 0 07 0 1 0 f 1 0  // ble taken
06 00 0 0 1 07 0 0 0 f 1 0  // ble not taken
23 00 0 0 0 05 0 0 0 f f 0  // lw is no longer decoded
00 3f 0 0 0 05 0 0 0 f f 0  // unknown funct

// ==== sim.f ====
hw/controlPkg.sv
hw/sequenceIf.sv
hw/instructionDecoder.sv
hw/stepCounter.sv
hw/phaseSequencer.sv
hw/controlSignalTable.sv
hw/controlUnit.sv
test/controlUnitTb.sv
